/* Bender.yml */
package:
  name: knn_classifier

sources:
  - src/knn_pkg.sv
  - src/knn_mem_if.sv
  - src/kbest_sorter.sv
  - src/majority_voter.sv
  - src/kbest_ram_arbiter.sv
  - src/knn_classifier_top.sv
  - target: simulation
    files:
      - tb/knn_chk.sv
      - tb/tb_knn.sv

/* src/kbest_ram_arbiter.sv */
`timescale 1ns/1ps
// ========================================
// K-best index RAM with fixed-priority arbiter
// Voter port first, sorter port second
// ========================================
module kbest_ram_arbiter
    import knn_pkg::*;
#(
    parameter int K = 5
) (
    input  logic       clk,
    input  logic       rst_n,
    knn_mem_if.arbiter sort_port,
    knn_mem_if.arbiter vote_port
);

    // One neighbour index per slot
    sample_idx_t mem [K];

    // ========================================
    // Grants
    // ========================================
    // Voter always wins, sorter waits holding its request
    assign vote_port.gnt = vote_port.req;
    assign sort_port.gnt = sort_port.req && !vote_port.req;

    // Granted write lands at this edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < K; i++) begin
                mem[i] <= '0;
            end
        end else if (vote_port.gnt && vote_port.we) begin
            mem[vote_port.addr] <= vote_port.wdata;
        end else if (sort_port.gnt && sort_port.we) begin
            mem[sort_port.addr] <= sort_port.wdata;
        end
    end

    // ========================================
    // Read ports
    // ========================================
    // Registered read data, valid the cycle after the grant
    always_ff @(posedge clk) begin
        if (vote_port.gnt && !vote_port.we) begin
            vote_port.rdata <= mem[vote_port.addr];
        end
        if (sort_port.gnt && !sort_port.we) begin
            sort_port.rdata <= mem[sort_port.addr];
        end
    end

endmodule

/* src/kbest_sorter.sv */
`timescale 1ns/1ps
// ========================================
// K-best sorter
// Sorted insertion of streamed distances, then
// write-back of the K nearest indices to the RAM
// ========================================
module kbest_sorter
    import knn_pkg::*;
#(
    parameter int K           = 5,
    parameter int NUM_SAMPLES = 16
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic         dist_valid,
    input  dist_t        dist_data,
    input  sample_idx_t  dist_index,
    output logic         dist_ready,
    output logic         sort_done,
    knn_mem_if.requester ram
);

    localparam int SLOT_W = (K > 1) ? $clog2(K) : 1;
    localparam int CNT_W  = $clog2(NUM_SAMPLES + 1);

    sort_state_e       state;
    sort_state_e       state_nxt;

    // Sorted buffer, slot 0 is the nearest
    dist_t             best_dist [K];
    sample_idx_t       best_idx  [K];

    // Sample under test
    dist_t             cur_dist;
    sample_idx_t       cur_idx;

    logic              hit;
    logic [SLOT_W-1:0] hit_pos;
    logic [SLOT_W-1:0] ins_pos;
    logic [CNT_W-1:0]  sample_cnt;
    logic [SLOT_W-1:0] wb_slot;
    // Start seen while still busy with the last query
    logic              start_pend;
    logic              go;
    logic              take;
    logic              last_sample;

    assign dist_ready  = (state == SORT_ACCEPT);
    assign take        = dist_valid && dist_ready;
    assign go          = start || start_pend;
    assign last_sample = (sample_cnt == CNT_W'(NUM_SAMPLES));

    // ========================================
    // Insertion slot search
    // ========================================
    // Lowest slot whose distance is strictly larger
    // Equal distance lands behind the older entry
    always_comb begin
        hit     = 1'b0;
        hit_pos = '0;
        for (int i = K - 1; i >= 0; i--) begin
            if (cur_dist < best_dist[i]) begin
                hit     = 1'b1;
                hit_pos = SLOT_W'(i);
            end
        end
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            SORT_IDLE:       if (go) state_nxt = SORT_ACCEPT;
            SORT_ACCEPT:     if (take) state_nxt = SORT_COMPARE;
            SORT_COMPARE: begin
                if (hit) begin
                    state_nxt = SORT_INSERT;
                end else if (last_sample) begin
                    state_nxt = SORT_WRITE_BACK;
                end else begin
                    state_nxt = SORT_ACCEPT;
                end
            end
            SORT_INSERT:     state_nxt = last_sample ? SORT_WRITE_BACK : SORT_ACCEPT;
            SORT_WRITE_BACK: begin
                // Last slot written, back to idle
                if (ram.gnt && wb_slot == SLOT_W'(K - 1)) state_nxt = SORT_IDLE;
            end
            default:         state_nxt = SORT_IDLE;
        endcase
    end

    // ========================================
    // Control registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SORT_IDLE;
            sample_cnt <= '0;
            wb_slot    <= '0;
            start_pend <= 1'b0;
            sort_done  <= 1'b0;
        end else begin
            state     <= state_nxt;
            sort_done <= 1'b0;
            // Hold an early start until idle
            if (state == SORT_IDLE) begin
                start_pend <= 1'b0;
            end else if (start) begin
                start_pend <= 1'b1;
            end
            case (state)
                SORT_IDLE: begin
                    sample_cnt <= '0;
                    wb_slot    <= '0;
                end
                SORT_ACCEPT: begin
                    if (take) sample_cnt <= sample_cnt + 1'b1;
                end
                SORT_WRITE_BACK: begin
                    if (ram.gnt) begin
                        wb_slot <= wb_slot + 1'b1;
                        // One-cycle pulse after the final write lands
                        if (wb_slot == SLOT_W'(K - 1)) sort_done <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // ========================================
    // Sorted buffer
    // ========================================
    always_ff @(posedge clk) begin
        case (state)
            SORT_IDLE: begin
                // Fresh buffer for every query
                if (go) begin
                    for (int i = 0; i < K; i++) begin
                        best_dist[i] <= '1;
                        best_idx[i]  <= '0;
                    end
                end
            end
            SORT_ACCEPT: begin
                if (take) begin
                    cur_dist <= dist_data;
                    cur_idx  <= dist_index;
                end
            end
            SORT_COMPARE: ins_pos <= hit_pos;
            SORT_INSERT: begin
                // Shift the farther entries down by one
                for (int i = 1; i < K; i++) begin
                    if (i > int'(ins_pos)) begin
                        best_dist[i] <= best_dist[i-1];
                        best_idx[i]  <= best_idx[i-1];
                    end
                end
                best_dist[ins_pos] <= cur_dist;
                best_idx[ins_pos]  <= cur_idx;
            end
            default: ;
        endcase
    end

    // Write-back, nearest first, held until granted
    assign ram.req   = (state == SORT_WRITE_BACK);
    assign ram.we    = 1'b1;
    assign ram.addr  = wb_slot;
    assign ram.wdata = best_idx[wb_slot];

endmodule

/* src/knn_classifier_top.sv */
`timescale 1ns/1ps
// ========================================
// KNN classifier back end, top level
// Sorter and voter sharing the k-best RAM
// ========================================
module knn_classifier_top
    import knn_pkg::*;
#(
    parameter int K           = 5,
    parameter int NUM_SAMPLES = 16,
    parameter int NUM_CLASSES = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    // Distance stream
    input  logic        dist_valid,
    input  dist_t       dist_data,
    input  sample_idx_t dist_index,
    output logic        dist_ready,
    // External label table, one-cycle read
    output logic        label_ren,
    output sample_idx_t label_raddr,
    input  label_t      label_rdata,
    // Classification result
    output logic        result_valid,
    output label_t      result_label,
    output vote_t       result_count
);

    // Sorter to voter handoff
    logic sort_done;

    // RAM ports of the two peers
    knn_mem_if #(.K(K)) sort_port ();
    knn_mem_if #(.K(K)) vote_port ();

    kbest_sorter #(
        .K           (K),
        .NUM_SAMPLES (NUM_SAMPLES)
    ) u_sorter (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .dist_valid (dist_valid),
        .dist_data  (dist_data),
        .dist_index (dist_index),
        .dist_ready (dist_ready),
        .sort_done  (sort_done),
        .ram        (sort_port)
    );

    majority_voter #(
        .K           (K),
        .NUM_CLASSES (NUM_CLASSES)
    ) u_voter (
        .clk          (clk),
        .rst_n        (rst_n),
        .sort_done    (sort_done),
        .label_rdata  (label_rdata),
        .label_ren    (label_ren),
        .label_raddr  (label_raddr),
        .result_valid (result_valid),
        .result_label (result_label),
        .result_count (result_count),
        .ram          (vote_port)
    );

    kbest_ram_arbiter #(
        .K (K)
    ) u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .sort_port (sort_port),
        .vote_port (vote_port)
    );

endmodule

/* src/knn_mem_if.sv */
`timescale 1ns/1ps
// ========================================
// One requester port into the k-best RAM
// ========================================
interface knn_mem_if
    import knn_pkg::*;
#(
    parameter int K = 5
) ();

    // Slot address, at least one bit
    localparam int SLOT_W = (K > 1) ? $clog2(K) : 1;

    logic              req;
    logic              gnt;
    logic              we;
    logic [SLOT_W-1:0] addr;
    sample_idx_t       wdata;
    // Read data, one cycle after the granted read
    sample_idx_t       rdata;

    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport arbiter   (input req, we, addr, wdata, output gnt, rdata);

endinterface

/* src/knn_pkg.sv */
// ========================================
// KNN classifier shared definitions
// Widths, data types and FSM state encodings
// ========================================
package knn_pkg;

    // ========================================
    // Widths
    // ========================================
    // One distance word
    localparam int DIST_W  = 16;
    // Sample index into the training set
    localparam int IDX_W   = 8;
    // Class label, up to 8 classes
    localparam int LABEL_W = 3;
    // Vote counter, enough for K up to 15
    localparam int VOTE_W  = 4;

    // ========================================
    // Data types
    // ========================================
    typedef logic [DIST_W-1:0]  dist_t;
    typedef logic [IDX_W-1:0]   sample_idx_t;
    typedef logic [LABEL_W-1:0] label_t;
    typedef logic [VOTE_W-1:0]  vote_t;

    // Sorter FSM
    typedef enum logic [2:0] {
        SORT_IDLE,
        SORT_ACCEPT,
        SORT_COMPARE,
        SORT_INSERT,
        SORT_WRITE_BACK
    } sort_state_e;

    // Voter FSM
    typedef enum logic [2:0] {
        VOTE_IDLE,
        VOTE_LOAD,
        VOTE_COUNT,
        VOTE_FIND_MAX,
        VOTE_RESULT
    } vote_state_e;

endpackage

/* src/majority_voter.sv */
`timescale 1ns/1ps
// ========================================
// Majority voter
// Fetches the labels of the K neighbours and
// returns the most frequent class and its count
// ========================================
module majority_voter
    import knn_pkg::*;
#(
    parameter int K           = 5,
    parameter int NUM_CLASSES = 8
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         sort_done,
    input  label_t       label_rdata,
    output logic         label_ren,
    output sample_idx_t  label_raddr,
    output logic         result_valid,
    output label_t       result_label,
    output vote_t        result_count,
    knn_mem_if.requester ram
);

    localparam int SLOT_W = (K > 1) ? $clog2(K) : 1;
    localparam int STEP_W = $clog2(K + 1);

    vote_state_e       state;
    vote_state_e       state_nxt;

    // Slot counter in LOAD, label pointer in COUNT
    logic [STEP_W-1:0] step;

    // Label fetch pipeline
    logic              lab_pend;
    logic [SLOT_W-1:0] lab_wr;
    label_t            lbuf [K];

    vote_t             votes [NUM_CLASSES];
    label_t            cls;
    vote_t             max_votes;
    label_t            win_label;

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            VOTE_IDLE:     if (sort_done) state_nxt = VOTE_LOAD;
            // K reads plus one trailing label fetch
            VOTE_LOAD:     if (step == STEP_W'(K)) state_nxt = VOTE_COUNT;
            VOTE_COUNT:    if (step == STEP_W'(K - 1)) state_nxt = VOTE_FIND_MAX;
            VOTE_FIND_MAX: if (cls == LABEL_W'(NUM_CLASSES - 1)) state_nxt = VOTE_RESULT;
            VOTE_RESULT:   state_nxt = VOTE_IDLE;
            default:       state_nxt = VOTE_IDLE;
        endcase
    end

    // ========================================
    // Control registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= VOTE_IDLE;
            step      <= '0;
            lab_pend  <= 1'b0;
            lab_wr    <= '0;
            cls       <= '0;
            max_votes <= '0;
            win_label <= '0;
        end else begin
            state    <= state_nxt;
            // Label answer lands one cycle after the request
            lab_pend <= label_ren;
            if (lab_pend) lab_wr <= lab_wr + 1'b1;
            case (state)
                VOTE_IDLE: begin
                    step   <= '0;
                    lab_wr <= '0;
                end
                VOTE_LOAD: begin
                    step <= (step == STEP_W'(K)) ? '0 : step + 1'b1;
                end
                VOTE_COUNT: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(K - 1)) begin
                        cls       <= '0;
                        max_votes <= '0;
                        win_label <= '0;
                    end
                end
                VOTE_FIND_MAX: begin
                    cls <= cls + 1'b1;
                    // Strict compare, lowest class keeps a tie
                    if (votes[cls] > max_votes) begin
                        max_votes <= votes[cls];
                        win_label <= cls;
                    end
                end
                default: ;
            endcase
        end
    end

    // ========================================
    // Label buffer and vote counters
    // ========================================
    always_ff @(posedge clk) begin
        if (state == VOTE_IDLE && sort_done) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                votes[c] <= '0;
            end
        end
        if (lab_pend) lbuf[lab_wr] <= label_rdata;
        // Last label arrives in the first COUNT cycle, read later
        if (state == VOTE_COUNT) begin
            votes[lbuf[step]] <= votes[lbuf[step]] + 1'b1;
        end
    end

    // RAM read of slot i while the label of slot i-1 is fetched
    assign ram.req   = (state == VOTE_LOAD) && (step < STEP_W'(K));
    assign ram.we    = 1'b0;
    assign ram.addr  = SLOT_W'(step);
    assign ram.wdata = '0;

    assign label_ren   = (state == VOTE_LOAD) && (step != '0);
    assign label_raddr = ram.rdata;

    assign result_valid = (state == VOTE_RESULT);
    assign result_label = win_label;
    assign result_count = max_votes;

endmodule

/* tb.f */
src/knn_pkg.sv
src/knn_mem_if.sv
src/kbest_sorter.sv
src/majority_voter.sv
src/kbest_ram_arbiter.sv
src/knn_classifier_top.sv
tb/knn_chk.sv
tb/tb_knn.sv

/* tb/knn_chk.sv */
`timescale 1ns/1ps
// ========================================
// Protocol assertions on the classifier top
// ========================================
module knn_chk (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic dist_ready,
    input logic label_ren,
    input logic result_valid,
    input logic sort_req,
    input logic sort_gnt,
    input logic vote_gnt
);

    int   fail_count = 0;
    // Set by the first start after reset
    logic started;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    // Result is a single-cycle pulse
    a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else begin
            $error("result_valid high for two cycles in a row");
            fail_count++;
        end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(sort_gnt && vote_gnt))
        else begin
            $error("both RAM ports granted in one cycle");
            fail_count++;
        end

    // No new samples during write-back
    a_ready_wb: assert property (@(posedge clk) disable iff (!rst_n)
        sort_req |-> !dist_ready)
        else begin
            $error("dist_ready high during write-back");
            fail_count++;
        end

    a_no_early_label: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !label_ren)
        else begin
            $error("label_ren high before the first start");
            fail_count++;
        end

endmodule

bind knn_classifier_top knn_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .dist_ready   (dist_ready),
    .label_ren    (label_ren),
    .result_valid (result_valid),
    .sort_req     (sort_port.req),
    .sort_gnt     (sort_port.gnt),
    .vote_gnt     (vote_port.gnt)
);

/* tb/tb_knn.sv */
`timescale 1ns/1ps
// ========================================
// KNN classifier testbench
// Directed queries checked against a reference model
// ========================================
module tb_knn
    import knn_pkg::*;
();

    localparam int K           = 5;
    localparam int NUM_SAMPLES = 16;
    localparam int NUM_CLASSES = 8;
    localparam int NUM_QUERIES = 7;
    localparam int READY_LIMIT = 64;
    localparam int RESULT_WAIT = 8 * NUM_SAMPLES;
    // Budget for all queries, reset and margin
    localparam int WATCHDOG_CYCLES = 8 * NUM_SAMPLES * NUM_QUERIES + 16 + 400;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        dist_valid;
    dist_t       dist_data;
    sample_idx_t dist_index;
    logic        dist_ready;
    logic        label_ren;
    sample_idx_t label_raddr;
    label_t      label_rdata;
    logic        result_valid;
    label_t      result_label;
    vote_t       result_count;

    // External label table contents
    label_t      label_table [256];
    // Distances of the query being built
    dist_t       q_dist [NUM_SAMPLES];
    // Expected results in issue order
    int          exp_label [$];
    int          exp_count [$];

    logic [31:0] rng_state;
    int          results_seen;
    int          mismatches;
    int          other_errors;
    int          assert_fails;

    knn_classifier_top #(
        .K           (K),
        .NUM_SAMPLES (NUM_SAMPLES),
        .NUM_CLASSES (NUM_CLASSES)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .dist_valid   (dist_valid),
        .dist_data    (dist_data),
        .dist_index   (dist_index),
        .dist_ready   (dist_ready),
        .label_ren    (label_ren),
        .label_raddr  (label_raddr),
        .label_rdata  (label_rdata),
        .result_valid (result_valid),
        .result_label (result_label),
        .result_count (result_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Label table answers one cycle after label_ren
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            label_rdata <= '0;
        end else if (label_ren) begin
            label_rdata <= label_table[label_raddr];
        end
    end

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            mismatches++;
            $display("Fail %s expected %h got %h", name, expected, actual);
        end
    endtask

    // Stable pick of the K nearest, then majority with lowest class on a tie
    task automatic predict_result(input int base);
        bit used [NUM_SAMPLES];
        int votes [NUM_CLASSES];
        int pick;
        int best_cnt;
        int best_cls;
        for (int i = 0; i < NUM_SAMPLES; i++) used[i] = 1'b0;
        for (int c = 0; c < NUM_CLASSES; c++) votes[c] = 0;
        for (int k = 0; k < K; k++) begin
            pick = -1;
            for (int i = 0; i < NUM_SAMPLES; i++) begin
                if (!used[i] && (pick < 0 || q_dist[i] < q_dist[pick])) pick = i;
            end
            used[pick] = 1'b1;
            votes[label_table[base + pick]]++;
        end
        best_cnt = 0;
        best_cls = 0;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            if (votes[c] > best_cnt) begin
                best_cnt = votes[c];
                best_cls = c;
            end
        end
        exp_label.push_back(best_cls);
        exp_count.push_back(best_cnt);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!dist_ready && n < READY_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (!dist_ready) begin
            other_errors++;
            $display("Error: dist_ready stayed low while a sample was offered");
        end
    endtask

    // Start pulse, then the stream with optional idle gaps
    task automatic drive_query(input int base, input int max_gap);
        int gap;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            dist_valid <= 1'b1;
            dist_data  <= q_dist[i];
            dist_index <= sample_idx_t'(base + i);
            wait_ready();
            @(posedge clk);
            gap = (max_gap > 0) ? int'(next_random() % (max_gap + 1)) : 0;
            if (gap > 0) begin
                dist_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        dist_valid <= 1'b0;
    endtask

    task automatic wait_results(input int target);
        int n;
        n = 0;
        while (results_seen < target && n < RESULT_WAIT) begin
            @(posedge clk);
            n++;
        end
        if (results_seen < target) begin
            other_errors++;
            $display("Error: result for query %0d never arrived", target);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < NUM_SAMPLES; i++) q_dist[i] = dist_t'(next_random() & 32'h7fff);
    endtask

    // Results compared in issue order
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (exp_label.size() == 0) begin
                other_errors++;
                $display("Error: a result came out with no query outstanding");
            end else begin
                check_value("result_label", exp_label.pop_front(), result_label);
                check_value("result_count", exp_count.pop_front(), result_count);
            end
            results_seen++;
        end
    end

    // ========================================
    // Directed tests
    // ========================================
    task automatic distinct_query();
        for (int i = 0; i < NUM_SAMPLES; i++) q_dist[i] = dist_t'(1000 - 50 * i);
        predict_result(0);
        drive_query(0, 0);
        wait_results(1);
    endtask

    task automatic random_query();
        fill_random();
        predict_result(16);
        drive_query(16, 0);
        wait_results(2);
    endtask

    // Of five samples at 40 only the first three fit behind 10 and 20
    task automatic distance_ties();
        for (int i = 0; i < NUM_SAMPLES; i++) q_dist[i] = dist_t'(200 - i);
        q_dist[4]  = 16'd10;
        q_dist[9]  = 16'd20;
        q_dist[2]  = 16'd40;
        q_dist[6]  = 16'd40;
        q_dist[11] = 16'd40;
        q_dist[13] = 16'd40;
        q_dist[15] = 16'd40;
        // Late arrivals would flip the winner to class 6
        label_table[32 + 2]  = 3'd1;
        label_table[32 + 6]  = 3'd1;
        label_table[32 + 11] = 3'd1;
        label_table[32 + 4]  = 3'd6;
        label_table[32 + 9]  = 3'd3;
        label_table[32 + 13] = 3'd6;
        label_table[32 + 15] = 3'd6;
        predict_result(32);
        drive_query(32, 0);
        wait_results(3);
    endtask

    // Classes 2 and 5 get two votes each
    task automatic vote_ties();
        for (int i = 0; i < NUM_SAMPLES; i++) q_dist[i] = dist_t'(500 - 7 * i);
        label_table[48 + 15] = 3'd5;
        label_table[48 + 14] = 3'd2;
        label_table[48 + 13] = 3'd5;
        label_table[48 + 12] = 3'd2;
        label_table[48 + 11] = 3'd7;
        predict_result(48);
        drive_query(48, 0);
        wait_results(4);
    endtask

    task automatic gapped_query();
        fill_random();
        predict_result(64);
        drive_query(64, 3);
        wait_results(5);
    endtask

    // Second stream starts while the first is still in the voter
    task automatic back_to_back_queries();
        fill_random();
        predict_result(80);
        drive_query(80, 0);
        fill_random();
        predict_result(96);
        drive_query(96, 0);
        wait_results(7);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        rng_state    = 32'hd5ea_3fd0;
        results_seen = 0;
        mismatches   = 0;
        other_errors = 0;
        for (int a = 0; a < 256; a++) label_table[a] = label_t'(next_random() % NUM_CLASSES);
        rst_n      = 1'b0;
        start      = 1'b0;
        dist_valid = 1'b0;
        dist_data  = '0;
        dist_index = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        distinct_query();
        random_query();
        distance_ties();
        vote_ties();
        gapped_query();
        back_to_back_queries();
        repeat (4) @(posedge clk);
        if (exp_label.size() != 0) begin
            other_errors++;
            $display("Error: %0d expected results still outstanding", exp_label.size());
        end
        assert_fails = DUT.u_chk.fail_count;
        $display("Mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 mismatches, other_errors, assert_fails);
        if (mismatches + other_errors + assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Hard stop if a query hangs
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: watchdog expired before all queries finished");
        $display("Regression failed");
        $finish;
    end

endmodule
